// File: hw/cdc_fifo_defs.svh
`ifndef CDC_FIFO_DEFS_SVH
`define CDC_FIFO_DEFS_SVH

`define CDC_DATA_W 8
`define CDC_DEPTH 16
`define CDC_ADDR_W 4

`define CDC_AFULL 12 // Write-side level at or above which afull is raised.
`define CDC_AEMPTY 2 // Read-side level at or below which aempty is raised.

`endif

// File: hw/cdc_fifo_pkg.sv
package cdc_fifo_pkg;

  `include "cdc_fifo_defs.svh"

  typedef logic [`CDC_DATA_W-1:0] data_t;
  typedef logic [`CDC_ADDR_W-1:0] addr_t;
  typedef logic [`CDC_ADDR_W:0]   ptr_t; // Extra top bit is the wrap flag.

  typedef enum logic {PUSH_IDLE, PUSH_ACK} push_state_e;

  typedef enum logic [1:0] {POP_IDLE, POP_READ, POP_REQ, POP_DONE} pop_state_e;

endpackage

// File: hw/dualport_ram.sv
`timescale 1ns/1ns
`include "cdc_fifo_defs.svh"

module dualport_ram (
  input  logic                wr_clk,
  input  logic                wr_en,
  input  cdc_fifo_pkg::addr_t wr_addr,
  input  cdc_fifo_pkg::data_t wr_data,
  input  logic                rd_clk,
  input  logic                rd_rst_n,
  input  logic                rd_en,
  input  cdc_fifo_pkg::addr_t rd_addr,
  output cdc_fifo_pkg::data_t rd_data
);

  import cdc_fifo_pkg::*;

  data_t mem [0:`CDC_DEPTH-1];

  always_ff @(posedge wr_clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rd_data <= '0;
    end else if (rd_en) begin
      rd_data <= mem[rd_addr]; // Word is valid one cycle after the request.
    end
  end

endmodule

// File: hw/gray_ptr_sync.sv
`timescale 1ns/1ns

module gray_ptr_sync (
  input  logic               clk,
  input  logic               rst_n,
  input  cdc_fifo_pkg::ptr_t gray_in,
  output cdc_fifo_pkg::ptr_t bin_out
);

  import cdc_fifo_pkg::*;

  ptr_t sync_q1;
  ptr_t sync_q2;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sync_q1 <= '0;
      sync_q2 <= '0;
    end else begin
      sync_q1 <= gray_in; // Only one bit moves per step, so a late sample is still a valid pointer.
      sync_q2 <= sync_q1;
    end
  end

  // Each binary bit is the XOR of the Gray bits at and above it.
  always_comb begin
    for (int i = 0; i < $bits(ptr_t); i++) begin
      bin_out[i] = ^(sync_q2 >> i);
    end
  end

endmodule

// File: hw/async_fifo.sv
`timescale 1ns/1ns
`include "cdc_fifo_defs.svh"

module async_fifo (
  input  logic                wr_clk,
  input  logic                wr_rst_n,
  input  logic                wr_en,
  input  cdc_fifo_pkg::data_t wr_data,
  output logic                full,
  output logic                afull,
  input  logic                rd_clk,
  input  logic                rd_rst_n,
  input  logic                rd_en,
  output cdc_fifo_pkg::data_t rd_data,
  output logic                empty,
  output logic                aempty
);

  import cdc_fifo_pkg::*;

  logic wr_vld;
  logic rd_vld;

  ptr_t wr_ptr;
  ptr_t wr_ptr_nxt;
  ptr_t wr_gray;
  ptr_t rd_ptr_wsync;
  ptr_t wr_level;

  ptr_t rd_ptr;
  ptr_t rd_ptr_nxt;
  ptr_t rd_gray;
  ptr_t wr_ptr_rsync;
  ptr_t rd_level;

  assign wr_vld = wr_en && !full; // Writes into a full FIFO are dropped.
  assign rd_vld = rd_en && !empty;

  assign wr_ptr_nxt = wr_ptr + ptr_t'(wr_vld);
  assign rd_ptr_nxt = rd_ptr + ptr_t'(rd_vld);

  assign wr_level = wr_ptr_nxt - rd_ptr_wsync; // Wrap bit keeps this in 0 to 16.
  assign rd_level = wr_ptr_rsync - rd_ptr_nxt;

  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      wr_ptr  <= '0;
      wr_gray <= '0;
      full    <= 1'b0;
      afull   <= 1'b0;
    end else begin
      wr_ptr  <= wr_ptr_nxt;
      wr_gray <= (wr_ptr_nxt >> 1) ^ wr_ptr_nxt;
      // Same address with the wrap bit flipped means the writer is a lap ahead.
      full    <= (wr_ptr_nxt == {~rd_ptr_wsync[`CDC_ADDR_W],
                                 rd_ptr_wsync[`CDC_ADDR_W-1:0]});
      afull   <= (wr_level >= ptr_t'(`CDC_AFULL));
    end
  end

  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rd_ptr  <= '0;
      rd_gray <= '0;
      empty   <= 1'b1;
      aempty  <= 1'b1;
    end else begin
      rd_ptr  <= rd_ptr_nxt;
      rd_gray <= (rd_ptr_nxt >> 1) ^ rd_ptr_nxt;
      empty   <= (rd_ptr_nxt == wr_ptr_rsync);
      aempty  <= (rd_level <= ptr_t'(`CDC_AEMPTY)); // The level errs low while writes cross.
    end
  end

  dualport_ram i_dualport_ram (
    .wr_clk   (wr_clk),
    .wr_en    (wr_vld),
    .wr_addr  (wr_ptr[`CDC_ADDR_W-1:0]),
    .wr_data  (wr_data),
    .rd_clk   (rd_clk),
    .rd_rst_n (rd_rst_n),
    .rd_en    (rd_vld),
    .rd_addr  (rd_ptr[`CDC_ADDR_W-1:0]),
    .rd_data  (rd_data)
  );

  // Read pointer into the write domain.
  gray_ptr_sync i_rd_ptr_sync (
    .clk     (wr_clk),
    .rst_n   (wr_rst_n),
    .gray_in (rd_gray),
    .bin_out (rd_ptr_wsync)
  );

  // Write pointer into the read domain.
  gray_ptr_sync i_wr_ptr_sync (
    .clk     (rd_clk),
    .rst_n   (rd_rst_n),
    .gray_in (wr_gray),
    .bin_out (wr_ptr_rsync)
  );

endmodule

// File: hw/req_ack_push.sv
`timescale 1ns/1ns

module req_ack_push (
  input  logic                wr_clk,
  input  logic                wr_rst_n,
  input  logic                in_req,
  input  cdc_fifo_pkg::data_t in_data,
  output logic                in_ack,
  input  logic                full,
  output logic                wr_en,
  output cdc_fifo_pkg::data_t wr_data
);

  import cdc_fifo_pkg::*;

  push_state_e state;
  logic        accept;

  assign accept = (state == PUSH_IDLE) && in_req && !full; // A full FIFO simply stalls the producer.

  assign in_ack = (state == PUSH_ACK);

  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      state <= PUSH_IDLE;
      wr_en <= 1'b0;
    end else begin
      wr_en <= accept; // One write per handshake, in the cycle in_ack rises.
      case (state)
        PUSH_IDLE: begin
          if (accept) begin
            state <= PUSH_ACK;
          end
        end
        PUSH_ACK: begin
          if (!in_req) begin
            state <= PUSH_IDLE;
          end
        end
        default: begin
          state <= PUSH_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge wr_clk) begin
    if (accept) begin
      wr_data <= in_data;
    end
  end

endmodule

// File: hw/req_ack_pop.sv
`timescale 1ns/1ns

module req_ack_pop (
  input  logic                rd_clk,
  input  logic                rd_rst_n,
  input  logic                empty,
  output logic                rd_en,
  input  cdc_fifo_pkg::data_t rd_data,
  output logic                out_req,
  input  logic                out_ack,
  output cdc_fifo_pkg::data_t out_data
);

  import cdc_fifo_pkg::*;

  pop_state_e state;
  pop_state_e state_nxt;

  always_comb begin
    state_nxt = state;
    case (state)
      POP_IDLE: begin
        if (!empty) begin
          state_nxt = POP_READ;
        end
      end
      POP_READ: begin
        state_nxt = POP_REQ; // RAM output is valid during this state.
      end
      POP_REQ: begin
        if (out_ack) begin
          state_nxt = POP_DONE;
        end
      end
      POP_DONE: begin
        if (!out_ack) begin
          state_nxt = POP_IDLE;
        end
      end
      default: begin
        state_nxt = POP_IDLE;
      end
    endcase
  end

  // The read is issued on the edge that enters POP_READ.
  assign rd_en = (state == POP_IDLE) && !empty;

  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      state   <= POP_IDLE;
      out_req <= 1'b0;
    end else begin
      state   <= state_nxt;
      out_req <= (state_nxt == POP_REQ);
    end
  end

  always_ff @(posedge rd_clk) begin
    if (state == POP_READ) begin
      out_data <= rd_data; // Held stable for the whole output handshake.
    end
  end

endmodule

// File: hw/cdc_link_top.sv
`timescale 1ns/1ns

module cdc_link_top (
  input  logic                wr_clk,
  input  logic                wr_rst_n,
  input  logic                in_req,
  input  cdc_fifo_pkg::data_t in_data,
  output logic                in_ack,
  input  logic                rd_clk,
  input  logic                rd_rst_n,
  output logic                out_req,
  output cdc_fifo_pkg::data_t out_data,
  input  logic                out_ack,
  output logic                afull,
  output logic                aempty
);

  import cdc_fifo_pkg::*;

  logic  wr_en;
  data_t wr_data;
  logic  full;
  logic  rd_en;
  data_t rd_data;
  logic  empty;

  req_ack_push i_req_ack_push (
    .wr_clk   (wr_clk),
    .wr_rst_n (wr_rst_n),
    .in_req   (in_req),
    .in_data  (in_data),
    .in_ack   (in_ack),
    .full     (full),
    .wr_en    (wr_en),
    .wr_data  (wr_data)
  );

  async_fifo i_async_fifo (
    .wr_clk   (wr_clk),
    .wr_rst_n (wr_rst_n),
    .wr_en    (wr_en),
    .wr_data  (wr_data),
    .full     (full),
    .afull    (afull),
    .rd_clk   (rd_clk),
    .rd_rst_n (rd_rst_n),
    .rd_en    (rd_en),
    .rd_data  (rd_data),
    .empty    (empty),
    .aempty   (aempty)
  );

  req_ack_pop i_req_ack_pop (
    .rd_clk   (rd_clk),
    .rd_rst_n (rd_rst_n),
    .empty    (empty),
    .rd_en    (rd_en),
    .rd_data  (rd_data),
    .out_req  (out_req),
    .out_ack  (out_ack),
    .out_data (out_data)
  );

endmodule

// File: verif/cdc_link_tb.sv
`timescale 1ns/1ns
`include "cdc_fifo_defs.svh"

module cdc_link_tb;

  import cdc_fifo_pkg::*;

  localparam int RD_HALF     = 20;
  localparam int WR_HALF     = 17;
  localparam int WAIT_LIMIT  = 400;
  localparam int STALL_LIMIT = 60; // Far longer than a push into a FIFO with room.
  localparam int QUIET_CYCLES = 12;

  logic  wr_clk;
  logic  wr_rst_n;
  logic  in_req;
  data_t in_data;
  logic  in_ack;
  logic  rd_clk;
  logic  rd_rst_n;
  logic  out_req;
  data_t out_data;
  logic  out_ack;
  logic  afull;
  logic  aempty;

  data_t ref_q[$]; // Words accepted by the DUT and not yet delivered.

  cdc_link_top i_cdc_link_top (
    .wr_clk   (wr_clk),
    .wr_rst_n (wr_rst_n),
    .in_req   (in_req),
    .in_data  (in_data),
    .in_ack   (in_ack),
    .rd_clk   (rd_clk),
    .rd_rst_n (rd_rst_n),
    .out_req  (out_req),
    .out_data (out_data),
    .out_ack  (out_ack),
    .afull    (afull),
    .aempty   (aempty)
  );

  initial begin
    rd_clk = 1'b0;
    forever begin
      #RD_HALF rd_clk = ~rd_clk;
    end
  end

  initial begin
    wr_clk = 1'b0;
    forever begin
      #WR_HALF wr_clk = ~wr_clk;
    end
  end

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("ERR %0t: %s is %0h, expected %0h", $time, what, actual, expected);
      $display("TEST FAILED");
      $fatal(1, "Value mismatch on %s.", what);
    end
  endtask

  task automatic report_timeout(input string what);
    $display("Timed out at %0t waiting for %s.", $time, what);
    $display("TEST FAILED");
    $fatal(1, "Wait limit reached.");
  endtask

  // One four-phase input cycle; accepted stays low if in_ack never rises.
  task automatic push_word(input data_t value, input int limit, output bit accepted);
    int cycles;
    accepted = 1'b0;
    cycles = 0;
    @(posedge wr_clk);
    in_data <= value;
    in_req  <= 1'b1;
    while (!accepted && cycles < limit) begin
      @(negedge wr_clk);
      cycles++;
      if (in_ack) begin
        accepted = 1'b1;
        ref_q.push_back(value);
      end
    end
    @(posedge wr_clk);
    in_req <= 1'b0;
    cycles = 0;
    while (accepted && in_ack) begin
      @(negedge wr_clk);
      cycles++;
      if (cycles > limit) begin
        report_timeout("in_ack to fall");
      end
    end
  endtask

  task automatic push_required(input data_t value);
    bit ok;
    push_word(value, WAIT_LIMIT, ok);
    if (!ok) begin
      report_timeout("in_ack to rise on a push with room in the FIFO");
    end
  endtask

  // One four-phase output cycle, checked against the head of the reference queue.
  task automatic pop_word();
    int    cycles;
    data_t expected;
    cycles = 0;
    do begin
      @(negedge rd_clk);
      cycles++;
      if (cycles > WAIT_LIMIT) begin
        report_timeout("out_req to rise");
      end
    end while (!out_req);
    if (ref_q.size() == 0) begin
      $display("Word %0h appeared on out_data with no word pending.", out_data);
      $display("TEST FAILED");
      $fatal(1, "Extra word delivered.");
    end
    expected = ref_q.pop_front();
    check_value(out_data, expected, "out_data");
    @(posedge rd_clk);
    out_ack <= 1'b1;
    cycles = 0;
    do begin
      @(negedge rd_clk);
      cycles++;
      if (cycles > WAIT_LIMIT) begin
        report_timeout("out_req to fall");
      end
    end while (out_req);
    @(posedge rd_clk);
    out_ack <= 1'b0;
  endtask

  // Every pushed word has been delivered, so any new request is a duplicate.
  task automatic expect_quiet_output(input string what);
    repeat (QUIET_CYCLES) begin
      @(negedge rd_clk);
      check_value(out_req, 1'b0, what);
    end
  endtask

  task automatic check_reset_state();
    @(negedge rd_clk);
    check_value(out_req, 1'b0, "out_req after reset");
    check_value(aempty, 1'b1, "aempty after reset");
    @(negedge wr_clk);
    check_value(in_ack, 1'b0, "in_ack after reset");
    check_value(afull, 1'b0, "afull after reset");
  endtask

  task automatic single_transfer();
    push_required(data_t'($urandom));
    pop_word();
  endtask

  task automatic ordered_stream();
    fork
      begin
        for (int i = 0; i < 40; i++) begin
          push_required(data_t'($urandom));
        end
      end
      begin
        for (int i = 0; i < 40; i++) begin
          pop_word();
        end
      end
    join
    expect_quiet_output("out_req after the stream");
  endtask

  task automatic backpressure_capacity();
    bit ok;
    int accepted;
    ok = 1'b1;
    accepted = 0;
    while (ok && accepted < `CDC_DEPTH + 4) begin
      push_word(data_t'($urandom), STALL_LIMIT, ok);
      if (ok) begin
        accepted++;
      end
    end
    check_value(accepted, `CDC_DEPTH + 1, "words accepted with out_ack withheld");
    repeat (10) @(posedge wr_clk);
    @(negedge wr_clk);
    check_value(afull, 1'b1, "afull with the FIFO full");
    repeat (accepted) pop_word();
    expect_quiet_output("out_req after draining");
  endtask

  task automatic level_flags_at_rest();
    repeat (10) @(posedge rd_clk);
    @(negedge rd_clk);
    check_value(aempty, 1'b1, "aempty when idle");
    @(negedge wr_clk);
    check_value(afull, 1'b0, "afull when idle");
    // The first word goes into the pop stage, the rest stay in the FIFO.
    repeat (`CDC_AEMPTY + 1) push_required(data_t'($urandom));
    repeat (10) @(posedge rd_clk);
    @(negedge rd_clk);
    check_value(out_req, 1'b1, "out_req with a word held");
    check_value(aempty, 1'b1, "aempty at the threshold");
    repeat (2) push_required(data_t'($urandom));
    repeat (10) @(posedge rd_clk);
    @(negedge rd_clk);
    check_value(aempty, 1'b0, "aempty above the threshold");
    repeat (`CDC_AEMPTY + 3) pop_word();
  endtask

  task automatic random_pacing();
    int    wr_gap [60];
    int    rd_gap [60];
    data_t words  [60];
    for (int i = 0; i < 60; i++) begin
      wr_gap[i] = $urandom % 6;
      rd_gap[i] = $urandom % 6;
      words[i]  = data_t'($urandom);
    end
    fork
      begin
        for (int i = 0; i < 60; i++) begin
          repeat (wr_gap[i]) @(posedge wr_clk);
          push_required(words[i]);
        end
      end
      begin
        for (int i = 0; i < 60; i++) begin
          repeat (rd_gap[i]) @(posedge rd_clk);
          pop_word();
        end
      end
    join
    expect_quiet_output("out_req after random pacing");
  endtask

  initial begin
    void'($urandom(32'h7e4fb09d));
    wr_rst_n = 1'b0;
    rd_rst_n = 1'b0;
    in_req   = 1'b0;
    in_data  = '0;
    out_ack  = 1'b0;
    repeat (16) @(posedge rd_clk);
    rd_rst_n <= 1'b1;
    @(posedge wr_clk);
    wr_rst_n <= 1'b1;
    repeat (4) @(posedge rd_clk);
    check_reset_state();
    single_transfer();
    ordered_stream();
    backpressure_capacity();
    level_flags_at_rest();
    random_pacing();
    $display("TEST PASSED");
    $finish;
  end

endmodule

// File: project.f
+incdir+hw
hw/cdc_fifo_pkg.sv
hw/dualport_ram.sv
hw/gray_ptr_sync.sv
hw/async_fifo.sv
hw/req_ack_push.sv
hw/req_ack_pop.sv
hw/cdc_link_top.sv
verif/cdc_link_tb.sv

// File: Bender.yml
package:
  name: cdc_link

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/cdc_fifo_pkg.sv
      - hw/dualport_ram.sv
      - hw/gray_ptr_sync.sv
      - hw/async_fifo.sv
      - hw/req_ack_push.sv
      - hw/req_ack_pop.sv
      - hw/cdc_link_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - verif/cdc_link_tb.sv
